// File: logic/irq_pkg.sv
// Interrupt controller definitions
package irq_pkg;

    // Number of interrupt lines unless the top sets another
    localparam int NUM_IRQ_DEFAULT = 8;

    // Register word indices, as seen in the address select slice
    localparam logic [1:0] REG_STATUS  = 2'd0;
    localparam logic [1:0] REG_PENDING = 2'd1;
    localparam logic [1:0] REG_MASK    = 2'd2;
    localparam logic [1:0] REG_RAW     = 2'd3;

    // Status word layout
    // Binary index of the winning line
    localparam int STATUS_BIN_LSB   = 0;
    // Gray coded index of the winning line
    localparam int STATUS_GRAY_LSB  = 8;
    // Set while any unmasked line is pending
    localparam int STATUS_VALID_BIT = 31;

endpackage

// File: logic/wb_pkg.sv
// Wishbone bus definitions
package wb_pkg;

    // Data bus width
    localparam int WB_DATA_W = 32;

    // Byte address width, four word registers
    localparam int WB_ADDR_W = 4;

    // Word register select, address bits 3:2
    localparam int REG_SEL_LSB = 2;
    localparam int REG_SEL_W   = 2;

endpackage

// File: logic/priority_encoder.sv
// Lowest set bit encoder
`timescale 1ns/100ps
module priority_encoder #(
    parameter int WIDTH = irq_pkg::NUM_IRQ_DEFAULT
) (
    input  logic [WIDTH-1:0]         data_in,
    output logic [$clog2(WIDTH)-1:0] binary_priority
);

    localparam int IDX_W = $clog2(WIDTH);

    logic [WIDTH-1:0] below_clear;
    logic [WIDTH-1:0] one_hot;

    // below_clear[i] is high when no bit under i is set
    assign below_clear[0] = 1'b1;

    genvar g;
    generate
        for (g = 1; g < WIDTH; g++) begin : g_prefix
            assign below_clear[g] = below_clear[g-1] & ~data_in[g-1];
        end
    endgenerate

    // At most one bit survives, the lowest one
    assign one_hot = data_in & below_clear;

    // OR together the indices of the surviving bit
    always_comb begin
        binary_priority = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (one_hot[i]) begin
                binary_priority = binary_priority | IDX_W'(i);
            end
        end
    end

endmodule

// File: logic/gray_code_priority_comp.sv
// Registered priority index in binary and Gray code
`timescale 1ns/100ps
module gray_code_priority_comp #(
    parameter int WIDTH = irq_pkg::NUM_IRQ_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [WIDTH-1:0]         data_in,
    output logic [$clog2(WIDTH)-1:0] binary_priority,
    output logic [$clog2(WIDTH)-1:0] gray_priority,
    output logic                     valid
);

    localparam int IDX_W = $clog2(WIDTH);

    logic [IDX_W-1:0] enc_index;
    logic             any_set;

    // Reflected binary code of an index
    function automatic logic [IDX_W-1:0] to_gray(input logic [IDX_W-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    priority_encoder #(
        .WIDTH(WIDTH)
    ) u_priority_encoder (
        .data_in        (data_in),
        .binary_priority(enc_index)
    );

    assign any_set = |data_in;

    // Index and flag update together so software never sees a mix
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid           <= 1'b0;
            binary_priority <= '0;
            gray_priority   <= '0;
        end else begin
            valid           <= any_set;
            binary_priority <= enc_index;
            gray_priority   <= to_gray(enc_index);
        end
    end

endmodule

// File: logic/irq_pending.sv
// Edge detect, pending and mask registers
`timescale 1ns/100ps
module irq_pending #(
    parameter int WIDTH = irq_pkg::NUM_IRQ_DEFAULT
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] irq,
    input  logic [WIDTH-1:0] clr_pulse,
    input  logic             mask_we,
    input  logic [WIDTH-1:0] mask_wdata,
    output logic [WIDTH-1:0] pending,
    output logic [WIDTH-1:0] mask,
    output logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] masked
);

    logic [WIDTH-1:0] irq_q;
    logic [WIDTH-1:0] rise;

    // Only a low to high step counts, a held line does not retrigger
    assign rise = irq & ~irq_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= '0;
        end else begin
            irq_q <= irq;
        end
    end

    // Clear first, then set, so a new edge beats a clear on the same bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_pulse) | rise;
        end
    end

    // All lines start masked
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask <= '0;
        end else if (mask_we) begin
            mask <= mask_wdata;
        end
    end

    // Current line levels for the RAW register
    assign raw = irq;

    // Requests that compete for the interrupt output
    assign masked = pending & mask;

endmodule

// File: logic/wb_irq_regs.sv
// Wishbone register slave
`timescale 1ns/100ps
module wb_irq_regs #(
    parameter int WIDTH = irq_pkg::NUM_IRQ_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [wb_pkg::WB_ADDR_W-1:0] wb_adr,
    input  logic [wb_pkg::WB_DATA_W-1:0] wb_dat_w,
    input  logic [3:0]                   wb_sel,
    output logic [wb_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                         wb_ack,
    input  logic [$clog2(WIDTH)-1:0]     binary_priority,
    input  logic [$clog2(WIDTH)-1:0]     gray_priority,
    input  logic                         valid,
    input  logic [WIDTH-1:0]             pending,
    input  logic [WIDTH-1:0]             mask,
    input  logic [WIDTH-1:0]             raw,
    output logic [WIDTH-1:0]             clr_pulse,
    output logic                         mask_we,
    output logic [WIDTH-1:0]             mask_wdata
);

    import irq_pkg::*;
    import wb_pkg::*;

    localparam int IDX_W = $clog2(WIDTH);

    logic                 access;
    logic                 wr_access;
    logic [REG_SEL_W-1:0] reg_sel;
    logic [WIDTH-1:0]     lane_bits;
    logic [WIDTH-1:0]     wr_bits;
    logic [WB_DATA_W-1:0] status_word;
    logic [WB_DATA_W-1:0] rd_data;

    // A new access is a strobe that has not been acknowledged yet
    assign access    = wb_cyc & wb_stb & ~wb_ack;
    assign wr_access = access & wb_we;
    assign reg_sel   = wb_adr[REG_SEL_LSB +: REG_SEL_W];

    // Byte lane that carries each interrupt bit
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            lane_bits[i] = wb_sel[i / 8];
        end
    end

    assign wr_bits = wb_dat_w[WIDTH-1:0] & lane_bits;

    // Write one to clear, lasts only the access cycle
    assign clr_pulse = (wr_access && reg_sel == REG_PENDING) ? wr_bits : '0;

    // Disabled lanes keep their old mask bits
    assign mask_we    = wr_access && (reg_sel == REG_MASK) && (|lane_bits);
    assign mask_wdata = wr_bits | (mask & ~lane_bits);

    always_comb begin
        status_word = '0;
        status_word[STATUS_BIN_LSB +: IDX_W]  = binary_priority;
        status_word[STATUS_GRAY_LSB +: IDX_W] = gray_priority;
        status_word[STATUS_VALID_BIT]         = valid;
    end

    // Read select, narrow registers are zero extended
    always_comb begin
        rd_data = '0;
        case (reg_sel)
            REG_STATUS:  rd_data = status_word;
            REG_PENDING: rd_data[WIDTH-1:0] = pending;
            REG_MASK:    rd_data[WIDTH-1:0] = mask;
            REG_RAW:     rd_data[WIDTH-1:0] = raw;
            default:     rd_data = '0;
        endcase
    end

    // One cycle ack per access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // Read data is captured on the ack edge and held until the next read
    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// File: logic/irq_ctrl_top.sv
// Interrupt controller top level
`timescale 1ns/100ps
module irq_ctrl_top #(
    parameter int WIDTH = irq_pkg::NUM_IRQ_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [wb_pkg::WB_ADDR_W-1:0] wb_adr,
    input  logic [wb_pkg::WB_DATA_W-1:0] wb_dat_w,
    input  logic [3:0]                   wb_sel,
    output logic [wb_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                         wb_ack,
    input  logic [WIDTH-1:0]             irq,
    output logic                         int_out
);

    logic [$clog2(WIDTH)-1:0] binary_priority;
    logic [$clog2(WIDTH)-1:0] gray_priority;
    logic                     valid;
    logic [WIDTH-1:0]         pending;
    logic [WIDTH-1:0]         mask;
    logic [WIDTH-1:0]         raw;
    logic [WIDTH-1:0]         masked;
    logic [WIDTH-1:0]         clr_pulse;
    logic                     mask_we;
    logic [WIDTH-1:0]         mask_wdata;

    wb_irq_regs #(
        .WIDTH(WIDTH)
    ) u_wb_irq_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_sel         (wb_sel),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .binary_priority(binary_priority),
        .gray_priority  (gray_priority),
        .valid          (valid),
        .pending        (pending),
        .mask           (mask),
        .raw            (raw),
        .clr_pulse      (clr_pulse),
        .mask_we        (mask_we),
        .mask_wdata     (mask_wdata)
    );

    irq_pending #(
        .WIDTH(WIDTH)
    ) u_irq_pending (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq       (irq),
        .clr_pulse (clr_pulse),
        .mask_we   (mask_we),
        .mask_wdata(mask_wdata),
        .pending   (pending),
        .mask      (mask),
        .raw       (raw),
        .masked    (masked)
    );

    gray_code_priority_comp #(
        .WIDTH(WIDTH)
    ) u_gray_code_priority_comp (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (masked),
        .binary_priority(binary_priority),
        .gray_priority  (gray_priority),
        .valid          (valid)
    );

    // The valid flag is the processor interrupt
    assign int_out = valid;

endmodule

// File: dv/irq_ctrl_checker.sv
// Wishbone and interrupt output checks
`timescale 1ns/100ps
module irq_ctrl_checker #(
    parameter int WIDTH = irq_pkg::NUM_IRQ_DEFAULT
) (
    input logic             clk,
    input logic             rst_n,
    input logic             wb_cyc,
    input logic             wb_stb,
    input logic             wb_ack,
    input logic             int_out,
    input logic [WIDTH-1:0] masked
);

    // Ack answers a strobe that the slave saw on the edge before
    ack_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_ack) |-> (wb_cyc && wb_stb && $past(wb_cyc && wb_stb)))
        else $error("wb_ack rose without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for two cycles");

    // The flag is registered from the masked vector
    int_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        int_out |-> $past(|masked))
        else $error("int_out high without a masked request on the previous cycle");

    int_low_in_reset: assert property (@(posedge clk)
        !rst_n |-> !int_out)
        else $error("int_out high during reset");

endmodule

// File: dv/irq_ctrl_tb.sv
// Interrupt controller testbench
`timescale 1ns/100ps
module irq_ctrl_tb;

    import irq_pkg::*;
    import wb_pkg::*;

    localparam int WIDTH       = NUM_IRQ_DEFAULT;
    localparam int IDX_W       = $clog2(WIDTH);
    localparam int ACK_LIMIT   = 8;
    localparam int CASE_CYCLES = 24;
    localparam int RAND_CYCLES = 32;

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [3:0]           wb_sel;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;
    logic [WIDTH-1:0]     irq;
    logic                 int_out;

    // Reference model of the pending and mask registers
    logic [WIDTH-1:0] ref_pending;
    logic [WIDTH-1:0] ref_mask;

    string       case_op[$];
    logic [31:0] case_addr[$];
    logic [31:0] case_data[$];
    logic [31:0] case_exp[$];

    int seed = 26;
    int errors;
    int test_errors;
    int tests_run;
    int checks;
    int budget;
    bit cases_loaded;

    irq_ctrl_top #(
        .WIDTH(WIDTH)
    ) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_sel  (wb_sel),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack),
        .irq     (irq),
        .int_out (int_out)
    );

    bind irq_ctrl_top irq_ctrl_checker #(
        .WIDTH(WIDTH)
    ) u_checker (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_ack (wb_ack),
        .int_out(int_out),
        .masked (masked)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [WB_ADDR_W-1:0] reg_addr(input logic [1:0] index);
        return WB_ADDR_W'(index) << REG_SEL_LSB;
    endfunction

    // Lowest unmasked pending line wins, so scan down and keep the last hit
    function automatic logic [WB_DATA_W-1:0] expected_status();
        logic [WIDTH-1:0]     req;
        logic [IDX_W-1:0]     idx;
        logic [WB_DATA_W-1:0] word;
        req  = ref_pending & ref_mask;
        idx  = '0;
        word = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) idx = IDX_W'(i);
        end
        word[STATUS_BIN_LSB +: IDX_W]  = idx;
        word[STATUS_GRAY_LSB +: IDX_W] = idx ^ (idx >> 1);
        word[STATUS_VALID_BIT]         = |req;
        return word;
    endfunction

    function automatic logic [WB_DATA_W-1:0] expected_read(input logic [WB_ADDR_W-1:0] addr);
        logic [WB_DATA_W-1:0] word;
        word = '0;
        case (addr[REG_SEL_LSB +: REG_SEL_W])
            REG_STATUS:  word = expected_status();
            REG_PENDING: word[WIDTH-1:0] = ref_pending;
            REG_MASK:    word[WIDTH-1:0] = ref_mask;
            default:     word[WIDTH-1:0] = irq;
        endcase
        return word;
    endfunction

    task automatic check_value(input string name, input logic [WB_DATA_W-1:0] exp_val,
                               input logic [WB_DATA_W-1:0] got);
        checks++;
        assert (got === exp_val) else begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp_val, got);
            errors++;
            test_errors++;
        end
    endtask

    // Pending moves one edge after the lines, the flag one edge later
    task automatic settle();
        repeat (3) @(posedge clk);
        check_value("int_out", WB_DATA_W'(|(ref_pending & ref_mask)), WB_DATA_W'(int_out));
    endtask

    task automatic bus_access(input logic we, input logic [WB_ADDR_W-1:0] addr,
                              input logic [WB_DATA_W-1:0] data, input logic [3:0] sel,
                              output logic [WB_DATA_W-1:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_dat_w <= data;
        wb_sel   <= sel;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        assert (wb_ack) else begin
            $display("ERROR at %0t: no acknowledge for access to address %h", $time, addr);
            errors++;
            test_errors++;
        end
    endtask

    task automatic reg_write(input logic [WB_ADDR_W-1:0] addr,
                             input logic [WB_DATA_W-1:0] data, input logic [3:0] sel);
        logic [WB_DATA_W-1:0] unused_rd;
        bus_access(1'b1, addr, data, sel, unused_rd);
        // Interrupt bits ride on byte lane 0 only
        if (sel[0] && addr[REG_SEL_LSB +: REG_SEL_W] == REG_MASK) begin
            ref_mask = data[WIDTH-1:0];
        end else if (sel[0] && addr[REG_SEL_LSB +: REG_SEL_W] == REG_PENDING) begin
            ref_pending = ref_pending & ~data[WIDTH-1:0];
        end
        settle();
    endtask

    task automatic reg_read(input logic [WB_ADDR_W-1:0] addr, input bit use_file,
                            input logic [WB_DATA_W-1:0] file_exp);
        logic [WB_DATA_W-1:0] rdata;
        bus_access(1'b0, addr, '0, 4'hf, rdata);
        check_value("wb_dat_r vs model", expected_read(addr), rdata);
        if (use_file) check_value("wb_dat_r vs case file", file_exp, rdata);
    endtask

    task automatic drive_lines(input logic [WIDTH-1:0] value);
        @(posedge clk);
        // Only lines that go from low to high become pending
        ref_pending = ref_pending | (value & ~irq);
        irq <= value;
        settle();
    endtask

    task automatic random_phase(input int steps);
        int                   kind;
        logic [WB_DATA_W-1:0] value;
        for (int s = 0; s < steps; s++) begin
            kind  = $unsigned($random(seed)) % 4;
            value = $random(seed);
            case (kind)
                0:       drive_lines(value[WIDTH-1:0]);
                1:       reg_write(reg_addr(REG_MASK), value, 4'hf);
                2:       reg_write(reg_addr(REG_PENDING), value, 4'hf);
                default: reg_read(reg_addr(value[1:0]), 1'b0, '0);
            endcase
            reg_read(reg_addr(REG_STATUS), 1'b0, '0);
        end
    endtask

    task automatic finish_test(input logic [31:0] id);
        tests_run++;
        $display("test %0d finished with %0d errors", id, test_errors);
        test_errors = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          extra;
        string       line;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        wb_sel      = '0;
        irq         = '0;
        ref_pending = '0;
        ref_mask    = '0;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;
        checks      = 0;
        extra       = 0;
        fd = $fopen("dv/irq_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open dv/irq_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#") continue;
                n = $sscanf(line, "%s %h %h %h", op, addr, data, exp_val);
                if (n == 4) begin
                    case_op.push_back(op);
                    case_addr.push_back(addr);
                    case_data.push_back(data);
                    case_exp.push_back(exp_val);
                    if (op == "wait") extra += int'(data);
                    if (op == "rand") extra += int'(data) * RAND_CYCLES;
                end
            end
            $fclose(fd);
        end
        budget       = 10 + case_op.size() * CASE_CYCLES + extra;
        cases_loaded = 1'b1;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        settle();

        for (int c = 0; c < case_op.size(); c++) begin
            op   = case_op[c];
            addr = case_addr[c];
            data = case_data[c];
            if (op == "irq") drive_lines(data[WIDTH-1:0]);
            else if (op == "wr") reg_write(addr[WB_ADDR_W-1:0], data, 4'hf);
            else if (op == "wr0") reg_write(addr[WB_ADDR_W-1:0], data, 4'he);
            else if (op == "rd") reg_read(addr[WB_ADDR_W-1:0], 1'b1, case_exp[c]);
            else if (op == "wait") repeat (data) @(posedge clk);
            else if (op == "rand") random_phase(int'(data));
            else if (op == "done") finish_test(data);
            else begin
                $display("ERROR: unknown operation %s in case %0d", op, c);
                errors++;
            end
        end

        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the loaded cases and the random steps
    initial begin
        wait (cases_loaded);
        repeat (budget) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish", budget);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: dv/irq_cases.txt
# op addr data expect, hex columns, addr is the byte address
# irq drives lines, wr and wr0 write with lane 0 on or off, rd compares, wait, rand steps, done id
# reset state
rd   0 0  00000000
rd   4 0  00000000
rd   8 0  00000000
done 0 1  0
# masked lines pend without an interrupt
irq  0 24 0
rd   4 0  00000024
rd   0 0  00000000
wr   8 20 0
rd   0 0  80000705
wr   8 24 0
rd   0 0  80000302
done 0 2  0
# walk every index by clearing the lowest
wr   8 ff 0
irq  0 ff 0
rd   0 0  80000000
wr   4 01 0
rd   0 0  80000101
wr   4 02 0
rd   0 0  80000302
wr   4 04 0
rd   0 0  80000203
wr   4 08 0
rd   0 0  80000604
wr   4 10 0
rd   0 0  80000705
wr   4 20 0
rd   0 0  80000506
wr   4 40 0
rd   0 0  80000407
done 0 3  0
wr   4 80 0
rd   4 0  00000000
rd   0 0  00000000
done 0 4  0
# held lines stay cleared until a new edge
wait 0 a  0
rd   4 0  00000000
irq  0 7f 0
irq  0 ff 0
rd   4 0  00000080
rd   0 0  80000407
rand 0 28 0
done 0 5  0
# raw levels and ignored writes
irq  0 00 0
wr   4 ff 0
wr   8 00 0
irq  0 5a 0
rd   c 0  0000005a
wr   0 ffffffff 0
wr   c ffffffff 0
wr0  8 ff 0
rd   4 0  0000005a
rd   8 0  00000000
rd   0 0  00000000
done 0 6  0

// File: filelist.f
logic/irq_pkg.sv
logic/wb_pkg.sv
logic/priority_encoder.sv
logic/gray_code_priority_comp.sv
logic/irq_pending.sv
logic/wb_irq_regs.sv
logic/irq_ctrl_top.sv
dv/irq_ctrl_checker.sv
dv/irq_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --timing --assert
TOP       = irq_ctrl_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = TEST FAIL

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A run that stops without a verdict is logged as a failure
sim: build
	./$(BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
